//--- common/ts_monitor_defs.svh
`ifndef TS_MONITOR_DEFS_SVH
`define TS_MONITOR_DEFS_SVH

// Transport packet framing
`define TS_PACKET_BYTES 188
`define TS_SYNC_BYTE 8'h47

// Readout word geometry
`define TS_WORD_BYTES 4
`define TS_PACKET_WORDS 47

// Filter table depth
`define TS_PID_SLOTS 4

`endif

//--- common/ts_monitor_pkg.sv
`default_nettype none

package ts_monitor_pkg;

	// Stream and header fields
	typedef logic [7:0] ts_byte_t;
	typedef logic [12:0] pid_t;

	// Register and readout words
	typedef logic [31:0] word_t;
	typedef logic [1:0] slot_t;

	// Positions inside a packet
	typedef logic [7:0] byte_index_t;
	typedef logic [5:0] word_index_t;

	typedef logic [31:0] count_t;

	typedef enum logic [1:0] {
		idle,
		wait_packet,
		stream
	} readout_state_t;

endpackage

`default_nettype wire

//--- common/ts_byte_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ts_byte_if;
	import ts_monitor_pkg::*;

	logic valid;
	ts_byte_t data;
	logic sop;
	// Only meaningful while sop is high
	pid_t pid;

	modport src (
		output valid,
		output data,
		output sop,
		output pid
	);

	modport dst (
		input valid,
		input data,
		input sop,
		input pid
	);

endinterface

`default_nettype wire

//--- hw/ts_pid_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "ts_monitor_defs.svh"

module ts_pid_table (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic pid_write,
	input wire ts_monitor_pkg::slot_t pid_index,
	input wire ts_monitor_pkg::word_t pid_wdata,
	output ts_monitor_pkg::word_t pid_rdata,
	input wire ts_monitor_pkg::pid_t lookup_pid,
	output logic hit
);
	import ts_monitor_pkg::*;

	pid_t slot_pid [`TS_PID_SLOTS];
	logic slot_en [`TS_PID_SLOTS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `TS_PID_SLOTS; i++) begin
				slot_pid[i] <= '0;
				slot_en[i] <= 1'b0;
			end
		end else begin
			if (pid_write) begin
				slot_pid[pid_index] <= pid_wdata[12:0];
				slot_en[pid_index] <= pid_wdata[16];
			end
		end
	end

	// PID in 12:0, enable in 16
	assign pid_rdata = {15'b0, slot_en[pid_index], 3'b0, slot_pid[pid_index]};

	// Any enabled slot may claim the packet
	always_comb begin
		hit = 1'b0;
		for (int i = 0; i < `TS_PID_SLOTS; i++) begin
			if (slot_en[i] && (slot_pid[i] == lookup_pid)) begin
				hit = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- ts_capture/ts_header_parser.sv
`timescale 1ns/1ps
`default_nettype none

`include "ts_monitor_defs.svh"

module ts_header_parser (
	input wire logic clk,
	input wire logic rst_n,
	input wire ts_monitor_pkg::ts_byte_t ts_data,
	input wire logic ts_valid,
	input wire logic ts_sync,
	ts_byte_if.src stream
);
	import ts_monitor_pkg::*;

	// Stages one and two of the delay line
	ts_byte_t data_d1;
	ts_byte_t data_d2;
	logic sync_d1;
	logic sync_d2;

	// Stage three is the output register
	ts_byte_t data_q;
	pid_t pid_q;
	logic valid_q;
	logic sop_q;

	logic start;

	// Sync byte two bytes back, so the current byte holds the PID low bits
	assign start = ts_valid && sync_d2 && (data_d2 == `TS_SYNC_BYTE);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sync_d1 <= 1'b0;
			sync_d2 <= 1'b0;
			valid_q <= 1'b0;
			sop_q <= 1'b0;
		end else begin
			valid_q <= ts_valid;
			if (ts_valid) begin
				sync_d1 <= ts_sync;
				sync_d2 <= sync_d1;
				sop_q <= start;
			end else begin
				sop_q <= 1'b0;
			end
		end
	end

	// Payload path
	always_ff @(posedge clk) begin
		if (ts_valid) begin
			data_d1 <= ts_data;
			data_d2 <= data_d1;
			data_q <= data_d2;
			pid_q <= {data_d1[4:0], ts_data};
		end
	end

	assign stream.valid = valid_q;
	assign stream.data = data_q;
	assign stream.sop = sop_q;
	assign stream.pid = pid_q;

endmodule

`default_nettype wire

//--- ts_capture/ts_packet_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "ts_monitor_defs.svh"

module ts_packet_buffer (
	input wire logic clk,
	input wire logic rst_n,
	ts_byte_if.dst stream,
	input wire logic hit,
	input wire logic match_enable,
	input wire logic hold,
	input wire ts_monitor_pkg::word_index_t read_addr,
	output ts_monitor_pkg::word_t read_word,
	output logic packet_ready,
	output ts_monitor_pkg::count_t matched_count
);
	import ts_monitor_pkg::*;

	word_t mem [`TS_PACKET_WORDS];

	byte_index_t wr_index;
	byte_index_t wr_pos;
	word_index_t wr_word;
	logic [1:0] wr_lane;
	logic capturing;
	logic qualified;
	logic start;
	logic wr_en;

	assign qualified = stream.valid && stream.sop && hit && match_enable;

	// Hold guards only a finished packet, otherwise a waiting readout never gets one
	assign start = qualified && !(hold && packet_ready);

	assign wr_en = start || (stream.valid && !stream.sop && capturing);
	assign wr_pos = start ? '0 : wr_index;
	assign wr_word = word_index_t'(wr_pos / `TS_WORD_BYTES);
	assign wr_lane = wr_pos[1:0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			capturing <= 1'b0;
			wr_index <= '0;
			packet_ready <= 1'b0;
			matched_count <= '0;
		end else begin
			if (qualified) begin
				matched_count <= matched_count + 1'b1;
			end

			if (start) begin
				capturing <= 1'b1;
				wr_index <= byte_index_t'(1);
				packet_ready <= 1'b0;
			end else if (stream.valid && stream.sop) begin
				// Cut off by a new start
				capturing <= 1'b0;
			end else if (wr_en) begin
				if (wr_index == byte_index_t'(`TS_PACKET_BYTES - 1)) begin
					capturing <= 1'b0;
					packet_ready <= 1'b1;
				end
				wr_index <= wr_index + 1'b1;
			end
		end
	end

	// Byte lanes, lane 0 is the low byte
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_word][wr_lane * 8 +: 8] <= stream.data;
		end
	end

	always_ff @(posedge clk) begin
		read_word <= mem[read_addr];
	end

endmodule

`default_nettype wire

//--- hw/ts_readout.sv
`timescale 1ns/1ps
`default_nettype none

`include "ts_monitor_defs.svh"

module ts_readout (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic pump_request,
	input wire logic packet_ready,
	output logic hold,
	output ts_monitor_pkg::word_index_t read_addr,
	input wire ts_monitor_pkg::word_t read_word,
	output logic out_valid,
	output ts_monitor_pkg::word_t out_data,
	output ts_monitor_pkg::word_index_t out_index,
	output logic readout_done
);
	import ts_monitor_pkg::*;

	localparam word_index_t last_word = word_index_t'(`TS_PACKET_WORDS - 1);

	readout_state_t state;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= idle;
			hold <= 1'b0;
			read_addr <= '0;
			out_valid <= 1'b0;
			out_index <= '0;
			readout_done <= 1'b0;
		end else begin
			readout_done <= 1'b0;
			case (state)
				idle: begin
					if (pump_request) begin
						state <= wait_packet;
						hold <= 1'b1;
						read_addr <= '0;
					end
				end
				wait_packet: begin
					// Word 0 is already addressed, so data follows next cycle
					if (packet_ready) begin
						state <= stream;
						out_valid <= 1'b1;
						out_index <= '0;
						read_addr <= word_index_t'(1);
					end
				end
				stream: begin
					if (out_index == last_word) begin
						state <= idle;
						out_valid <= 1'b0;
						readout_done <= 1'b1;
						hold <= 1'b0;
					end else begin
						out_index <= out_index + 1'b1;
					end
					if (read_addr != last_word) begin
						read_addr <= read_addr + 1'b1;
					end
				end
				default: begin
					state <= idle;
					hold <= 1'b0;
					out_valid <= 1'b0;
				end
			endcase
		end
	end

	// Read port is registered, one cycle behind read_addr
	assign out_data = read_word;

endmodule

`default_nettype wire

//--- hw/ts_monitor_top.sv
`timescale 1ns/1ps
`default_nettype none

module ts_monitor_top (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic match_enable,
	input wire logic pid_write,
	input wire ts_monitor_pkg::slot_t pid_index,
	input wire ts_monitor_pkg::word_t pid_wdata,
	output ts_monitor_pkg::word_t pid_rdata,
	input wire ts_monitor_pkg::ts_byte_t ts_data,
	input wire logic ts_valid,
	input wire logic ts_sync,
	input wire logic pump_request,
	output logic out_valid,
	output ts_monitor_pkg::word_t out_data,
	output ts_monitor_pkg::word_index_t out_index,
	output logic readout_done,
	output ts_monitor_pkg::count_t matched_count
);
	import ts_monitor_pkg::*;

	logic hit;
	logic hold;
	logic packet_ready;
	word_index_t read_addr;
	word_t read_word;

	ts_byte_if byte_stream ();

	ts_pid_table u_pid_table (
		.clk (clk),
		.rst_n (rst_n),
		.pid_write (pid_write),
		.pid_index (pid_index),
		.pid_wdata (pid_wdata),
		.pid_rdata (pid_rdata),
		.lookup_pid (byte_stream.pid),
		.hit (hit)
	);

	ts_header_parser u_header_parser (
		.clk (clk),
		.rst_n (rst_n),
		.ts_data (ts_data),
		.ts_valid (ts_valid),
		.ts_sync (ts_sync),
		.stream (byte_stream.src)
	);

	ts_packet_buffer u_packet_buffer (
		.clk (clk),
		.rst_n (rst_n),
		.stream (byte_stream.dst),
		.hit (hit),
		.match_enable (match_enable),
		.hold (hold),
		.read_addr (read_addr),
		.read_word (read_word),
		.packet_ready (packet_ready),
		.matched_count (matched_count)
	);

	ts_readout u_readout (
		.clk (clk),
		.rst_n (rst_n),
		.pump_request (pump_request),
		.packet_ready (packet_ready),
		.hold (hold),
		.read_addr (read_addr),
		.read_word (read_word),
		.out_valid (out_valid),
		.out_data (out_data),
		.out_index (out_index),
		.readout_done (readout_done)
	);

endmodule

`default_nettype wire

//--- dv/ts_monitor_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ts_monitor_defs.svh"

module ts_monitor_tb;
	import ts_monitor_pkg::*;

	localparam int wait_limit = 2000;

	logic clk;
	logic rst_n;
	logic match_enable;
	logic pid_write;
	slot_t pid_index;
	word_t pid_wdata;
	word_t pid_rdata;
	ts_byte_t ts_data;
	logic ts_valid;
	logic ts_sync;
	logic pump_request;
	logic out_valid;
	word_t out_data;
	word_index_t out_index;
	logic readout_done;
	count_t matched_count;

	// Model of the PID table, counter and last captured packet
	logic [31:0] lcg_state;
	pid_t table_pid [`TS_PID_SLOTS];
	logic table_en [`TS_PID_SLOTS];
	ts_byte_t pkt [`TS_PACKET_BYTES];
	ts_byte_t model_pkt [`TS_PACKET_BYTES];
	logic model_ready;
	logic readout_pending;
	int model_count;
	int errors;
	int failures;

	ts_monitor_top UUT (
		.clk (clk),
		.rst_n (rst_n),
		.match_enable (match_enable),
		.pid_write (pid_write),
		.pid_index (pid_index),
		.pid_wdata (pid_wdata),
		.pid_rdata (pid_rdata),
		.ts_data (ts_data),
		.ts_valid (ts_valid),
		.ts_sync (ts_sync),
		.pump_request (pump_request),
		.out_valid (out_valid),
		.out_data (out_data),
		.out_index (out_index),
		.readout_done (readout_done),
		.matched_count (matched_count)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic pid_t random_pid();
		word_t r;
		r = next_random();
		return r[28:16];
	endfunction

	function automatic logic pid_enabled(input pid_t pid);
		logic found;
		found = 1'b0;
		for (int i = 0; i < `TS_PID_SLOTS; i++) begin
			if (table_en[i] && (table_pid[i] == pid)) begin
				found = 1'b1;
			end
		end
		return found;
	endfunction

	// Byte i sits in lane i mod 4 of word i / 4
	function automatic word_t expected_word(input int w);
		return {model_pkt[4 * w + 3], model_pkt[4 * w + 2],
			model_pkt[4 * w + 1], model_pkt[4 * w]};
	endfunction

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("** Error: %s expected 0x%h actual 0x%h at %0t",
				name, expected, actual, $time);
			errors++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("Failure: %s at %0t", what, $time);
		failures++;
	endtask

	task automatic write_slot(input int slot, input word_t value);
		pid_write = 1'b1;
		pid_index = slot_t'(slot);
		pid_wdata = value;
		tick();
		pid_write = 1'b0;
		table_pid[slot] = value[12:0];
		table_en[slot] = value[16];
	endtask

	task automatic read_slot(input int slot, input word_t expected);
		pid_index = slot_t'(slot);
		tick();
		check_value("pid_rdata", expected, pid_rdata);
	endtask

	task automatic send_byte(input ts_byte_t value, input logic sync);
		int gap;
		gap = (next_random() >> 16) % 3;
		ts_valid = 1'b0;
		repeat (gap) tick();
		ts_valid = 1'b1;
		ts_data = value;
		ts_sync = sync;
		tick();
		ts_valid = 1'b0;
		ts_sync = 1'b0;
	endtask

	task automatic send_packet(input pid_t pid, input int length);
		word_t r;
		logic matched;
		r = next_random();
		pkt[0] = `TS_SYNC_BYTE;
		pkt[1] = {r[23:21], pid[12:8]};
		pkt[2] = pid[7:0];
		for (int i = 3; i < `TS_PACKET_BYTES; i++) begin
			r = next_random();
			pkt[i] = r[23:16];
		end
		for (int i = 0; i < length; i++) begin
			send_byte(pkt[i], i == 0);
		end
		matched = match_enable && pid_enabled(pid);
		if (matched) begin
			model_count++;
			// A finished packet is kept while a readout waits on it
			if (!(readout_pending && model_ready)) begin
				if (length == `TS_PACKET_BYTES) begin
					model_pkt = pkt;
					model_ready = 1'b1;
				end else begin
					model_ready = 1'b0;
				end
			end
		end
	endtask

	// Pushes the last two bytes out of the parser delay line
	task automatic flush_stream();
		word_t r;
		r = next_random();
		send_byte(r[23:16], 1'b0);
		send_byte(r[31:24], 1'b0);
	endtask

	task automatic send_random_packets(input int count, input logic end_with_match);
		pid_t pid;
		int kind;
		for (int p = 0; p < count; p++) begin
			kind = (next_random() >> 16) % 5;
			if (kind < `TS_PID_SLOTS) begin
				pid = table_pid[kind];
			end else begin
				pid = random_pid();
			end
			if (end_with_match && (p == count - 1)) begin
				pid = table_pid[0];
			end
			send_packet(pid, `TS_PACKET_BYTES);
		end
		flush_stream();
	endtask

	task automatic check_count();
		repeat (3) tick();
		check_value("matched_count", model_count, matched_count);
	endtask

	task automatic request_readout();
		pump_request = 1'b1;
		tick();
		pump_request = 1'b0;
		readout_pending = 1'b1;
	endtask

	task automatic collect_readout();
		int n;
		n = 0;
		while (!out_valid && (n < wait_limit)) begin
			tick();
			n++;
		end
		if (!out_valid) begin
			report_failure("readout never produced data after the request");
		end else begin
			for (int w = 0; w < `TS_PACKET_WORDS; w++) begin
				check_value("out_valid", 1, out_valid);
				check_value("out_index", w, out_index);
				check_value("out_data", expected_word(w), out_data);
				check_value("readout_done", 0, readout_done);
				// Extra request mid-stream must be ignored
				pump_request = (w == 10);
				tick();
			end
			pump_request = 1'b0;
			check_value("out_valid", 0, out_valid);
			check_value("readout_done", 1, readout_done);
			repeat (10) begin
				tick();
				check_value("out_valid", 0, out_valid);
				check_value("readout_done", 0, readout_done);
			end
		end
		readout_pending = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		match_enable = 1'b0;
		pid_write = 1'b0;
		pid_index = '0;
		pid_wdata = '0;
		ts_data = '0;
		ts_valid = 1'b0;
		ts_sync = 1'b0;
		pump_request = 1'b0;
		lcg_state = 32'd16;
		model_ready = 1'b0;
		readout_pending = 1'b0;
		model_count = 0;
		errors = 0;
		failures = 0;
		for (int i = 0; i < `TS_PID_SLOTS; i++) begin
			table_pid[i] = '0;
			table_en[i] = 1'b0;
		end
		repeat (5) tick();
		rst_n = 1'b1;
		tick();

		check_value("matched_count", 0, matched_count);
		check_value("out_valid", 0, out_valid);
		check_value("readout_done", 0, readout_done);
		for (int i = 0; i < `TS_PID_SLOTS; i++) begin
			read_slot(i, 32'h0);
		end

		// Only PID and enable bits survive a write
		for (int i = 0; i < `TS_PID_SLOTS; i++) begin
			pid_wdata = next_random();
			write_slot(i, pid_wdata);
			read_slot(i, pid_wdata & 32'h0001_1fff);
		end

		// Working table with slot 3 disabled
		for (int i = 0; i < `TS_PID_SLOTS; i++) begin
			write_slot(i, ((i < 3) ? 32'h0001_0000 : 32'h0) | word_t'(random_pid()));
		end

		match_enable = 1'b1;
		send_random_packets(16, 1'b1);
		check_count();
		match_enable = 1'b0;
		send_random_packets(4, 1'b0);
		check_count();
		match_enable = 1'b1;
		request_readout();
		collect_readout();

		send_random_packets(8, 1'b1);
		check_count();
		request_readout();
		collect_readout();

		// Match cut short by a start on the disabled slot
		send_packet(table_pid[1], 60);
		send_packet(table_pid[3], `TS_PACKET_BYTES);
		flush_stream();
		check_count();
		request_readout();
		repeat (50) begin
			tick();
			check_value("out_valid", 0, out_valid);
		end
		send_packet(table_pid[2], `TS_PACKET_BYTES);
		flush_stream();
		collect_readout();
		check_count();

		$display("Errors: %0d value mismatches, %0d other failures", errors, failures);
		if ((errors == 0) && (failures == 0)) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- ts_monitor_top.f
+incdir+common
common/ts_monitor_pkg.sv
common/ts_byte_if.sv
hw/ts_pid_table.sv
ts_capture/ts_header_parser.sv
ts_capture/ts_packet_buffer.sv
hw/ts_readout.sv
hw/ts_monitor_top.sv
dv/ts_monitor_tb.sv
